/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, FILELIST, BUILD_DIR, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src.f */
verilog/cache_pkg.sv
verilog/axi_pkg.sv
verilog/mem_req_if.sv
verilog/axi_bridge.sv
verilog/cache_ctrl.sv
verilog/cache_cfg.sv
verilog/dcache_top.sv
tb/axi_mem_model.sv
tb/tb_dcache.sv

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int DEPTH = 1024
) (
    input logic clk,
    input logic rstn,
    input logic stall,
    input cache_pkg::addr_t araddr,
    input axi_pkg::len_t arlen,
    input axi_pkg::size_t arsize,
    input logic arvalid,
    output logic arready,
    input cache_pkg::addr_t awaddr,
    input axi_pkg::len_t awlen,
    input axi_pkg::size_t awsize,
    input logic awvalid,
    output logic awready,
    input cache_pkg::word_t wdata,
    input cache_pkg::strb_t wstrb,
    input logic wlast,
    input logic wvalid,
    output logic wready,
    output cache_pkg::word_t rdata,
    output axi_pkg::resp_t rresp,
    output logic rlast,
    output logic rvalid,
    input logic rready,
    output axi_pkg::resp_t bresp,
    output logic bvalid,
    input logic bready
);

    localparam int AW = $clog2(DEPTH);

    cache_pkg::word_t mem [DEPTH];
    axi_pkg::len_t lens [$];    // Burst lengths in arrival order, reads and writes alike.
    axi_pkg::size_t sizes [$];    // Beat sizes, in the same order as the lengths.
    cache_pkg::addr_t rd_addr;
    cache_pkg::addr_t wr_addr;
    axi_pkg::len_t rd_left;
    logic rd_busy;
    logic wr_busy;
    logic b_pend;

    assign rresp = axi_pkg::RESP_OKAY;
    assign bresp = axi_pkg::RESP_OKAY;

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            arready <= 1'b0;
            awready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rdata <= '0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            b_pend <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= (i * 4) ^ 32'h5a5a_0000;    // Word at byte address a holds a ^ 5a5a0000.
            end
        end else begin
            arready <= 1'b0;
            if (arvalid && !arready && !rd_busy && !stall) begin
                arready <= 1'b1;
                rd_addr <= araddr;
                rd_left <= arlen;
                rd_busy <= 1'b1;
                lens.push_back(arlen);
                sizes.push_back(arsize);
            end
            if (rvalid && rready && rlast) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
                rd_busy <= 1'b0;
            end else if (rd_busy && !arready && (!rvalid || rready)) begin
                rvalid <= !stall;
                if (!stall) begin
                    rdata <= mem[rd_addr[AW+1:2]];
                    rlast <= (rd_left == 8'd0);
                    rd_addr <= rd_addr + 32'd4;
                    rd_left <= rd_left - 8'd1;
                end
            end

            awready <= 1'b0;
            if (awvalid && !awready && !wr_busy && !stall) begin
                awready <= 1'b1;
                wr_addr <= awaddr;
                wr_busy <= 1'b1;
                lens.push_back(awlen);
                sizes.push_back(awsize);
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[wr_addr[AW+1:2]][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
                wr_addr <= wr_addr + 32'd4;
                wready <= !wlast && !stall;
                b_pend <= wlast;
            end else if (wr_busy && wvalid && !b_pend) begin
                wready <= !stall;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
                wr_busy <= 1'b0;
            end else if (b_pend && !stall) begin
                bvalid <= 1'b1;
            end
        end
    end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam logic [31:0] SEED = 32'h96ba_2ea6;
    // About 300 accesses of up to 40 cycles each under stalls, plus margin.
    localparam int MAX_CYCLES = 20000;
    localparam cache_pkg::addr_t LINE_A = 32'h0000_0120;    // Tag 1, index 1.
    localparam cache_pkg::addr_t LINE_B = 32'h0000_0220;    // Tag 2, index 1.
    localparam cache_pkg::addr_t LINE_C = 32'h0000_0344;

    logic clk;
    logic rstn;
    logic cpu_req;
    logic cpu_we;
    cache_pkg::addr_t cpu_addr;
    cache_pkg::word_t cpu_wdata;
    cache_pkg::strb_t cpu_wstrb;
    axi_pkg::size_t cpu_size;
    logic cpu_ready;
    logic cpu_done;
    cache_pkg::word_t cpu_rdata;
    logic cfg_wr;
    logic [1:0] cfg_addr;
    cache_pkg::word_t cfg_wdata;
    cache_pkg::word_t cfg_rdata;
    cache_pkg::addr_t araddr;
    cache_pkg::addr_t awaddr;
    axi_pkg::len_t arlen;
    axi_pkg::len_t awlen;
    axi_pkg::size_t arsize;
    axi_pkg::size_t awsize;
    logic arvalid, arready;
    logic awvalid, awready;
    cache_pkg::word_t wdata;
    cache_pkg::strb_t wstrb;
    logic wlast, wvalid, wready;
    cache_pkg::word_t rdata;
    axi_pkg::resp_t rresp;
    axi_pkg::resp_t bresp;
    logic rlast, rvalid, rready;
    logic bvalid, bready;
    logic stall;
    logic stall_on;

    logic [31:0] stim_lfsr = SEED;
    logic [31:0] stall_lfsr = SEED;
    int cycles = 0;
    cache_pkg::word_t shadow [cache_pkg::addr_t];

    dcache_top #(.NUM_LINES(8)) dut (.*);

    axi_mem_model mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            report_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // Stall bits change on the falling edge so the model sees them settled.
    always @(negedge clk) begin
        if (stall_on) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            stall <= stall_lfsr[0];
        end else begin
            stall <= 1'b0;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic cache_pkg::word_t rand_bits(input int n);
        cache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old,
                                                     input cache_pkg::word_t d,
                                                     input cache_pkg::strb_t s);
        cache_pkg::word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                r[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic cache_pkg::word_t expect_word(input cache_pkg::addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a_0000);
    endfunction

    function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
        return mem_model.mem[a[11:2]];
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s: got %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                               input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s: got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_len(input axi_pkg::len_t got, input axi_pkg::len_t exp,
                             input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s: got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_size(input axi_pkg::size_t got, input axi_pkg::size_t exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s: got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic cfg_write(input cache_pkg::word_t v);
        @(posedge clk);
        cfg_wr <= 1'b1;
        cfg_wdata <= v;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic cfg_read(input logic [1:0] a, output cache_pkg::word_t v);
        @(posedge clk);
        cfg_addr <= a;
        @(negedge clk);
        v = cfg_rdata;
    endtask

    task automatic cpu_access(input logic we, input cache_pkg::addr_t a,
                              input cache_pkg::word_t d, input cache_pkg::strb_t s,
                              input axi_pkg::size_t sz, output cache_pkg::word_t rd);
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        cpu_req <= 1'b1;
        cpu_we <= we;
        cpu_addr <= a;
        cpu_wdata <= d;
        cpu_wstrb <= s;
        cpu_size <= sz;
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        while (!cpu_done) @(negedge clk);
        rd = cpu_rdata;
    endtask

    task automatic load_expect(input cache_pkg::addr_t a, input string what);
        cache_pkg::word_t rd;
        cpu_access(1'b0, a, '0, '0, axi_pkg::WORD_SIZE, rd);
        check_word(rd, expect_word(a), what);
    endtask

    task automatic store_word(input cache_pkg::addr_t a, input cache_pkg::word_t d,
                              input cache_pkg::strb_t s);
        cache_pkg::word_t rd;
        shadow[a] = merge_bytes(expect_word(a), d, s);
        cpu_access(1'b1, a, d, s, axi_pkg::WORD_SIZE, rd);
    endtask

    task automatic reset_values();
        cache_pkg::word_t v;
        @(negedge clk);
        check_word({31'b0, cpu_ready}, 32'd1, "cpu_ready after reset");
        check_word({26'b0, arvalid, awvalid, wvalid, rready, bready, cpu_done}, 32'd0,
                   "valids and done after reset");
        for (int a = 0; a < 3; a++) begin
            cfg_read(a[1:0], v);
            check_count(v, 32'd0, "configuration register after reset");
        end
    endtask

    task automatic read_miss_fill();
        cache_pkg::word_t v;
        int n0;
        cfg_write(32'd1);
        n0 = mem_model.lens.size();
        for (int w = 0; w < 8; w++) begin
            load_expect(LINE_A + w * 4, "load from filled line");
        end
        check_count(mem_model.lens.size() - n0, 32'd1, "bursts for one fill");
        check_len(mem_model.lens[n0], 8'd7, "fill burst length");
        check_size(mem_model.sizes[n0], axi_pkg::WORD_SIZE, "fill beat size");
        cfg_read(2'd2, v);
        check_count(v, 32'd1, "miss count");
        cfg_read(2'd1, v);
        check_count(v, 32'd7, "hit count");
    endtask

    task automatic store_hit_merge();
        int n0;
        n0 = mem_model.lens.size();
        store_word(LINE_A + 8, 32'hdead_beef, 4'b0101);
        load_expect(LINE_A + 8, "load after partial store");
        check_count(mem_model.lens.size() - n0, 32'd0, "bursts during store hit");
    endtask

    task automatic dirty_eviction();
        int n0;
        n0 = mem_model.lens.size();
        load_expect(LINE_B, "load that evicts a dirty line");
        check_count(mem_model.lens.size() - n0, 32'd2, "bursts for write-back and fill");
        check_len(mem_model.lens[n0], 8'd7, "write-back burst length");
        check_len(mem_model.lens[n0 + 1], 8'd7, "fill burst length");
        check_size(mem_model.sizes[n0], axi_pkg::WORD_SIZE, "write-back beat size");
        check_size(mem_model.sizes[n0 + 1], axi_pkg::WORD_SIZE, "fill beat size");
        check_word(mem_word(LINE_A + 8), expect_word(LINE_A + 8), "memory after write-back");
        load_expect(LINE_A + 8, "reload after eviction");
    endtask

    task automatic uncached_access();
        cache_pkg::word_t hits;
        cache_pkg::word_t misses;
        cache_pkg::word_t v;
        int n0;
        cfg_write(32'd0);
        cfg_read(2'd1, hits);
        cfg_read(2'd2, misses);
        n0 = mem_model.lens.size();
        load_expect(LINE_C, "uncached load");
        store_word(LINE_C, 32'h1234_5678, 4'b1100);
        check_word(mem_word(LINE_C), expect_word(LINE_C), "memory after uncached store");
        load_expect(LINE_C, "uncached load after store");
        // A halfword load carries its own size onto the read channel.
        cpu_access(1'b0, LINE_C + 2, '0, '0, 3'd1, v);
        check_word(v, expect_word(LINE_C), "uncached halfword load");
        check_count(mem_model.lens.size() - n0, 32'd4, "bursts for uncached accesses");
        for (int i = 0; i < 4; i++) begin
            check_len(mem_model.lens[n0 + i], 8'd0, "uncached burst length");
        end
        for (int i = 0; i < 3; i++) begin
            check_size(mem_model.sizes[n0 + i], axi_pkg::WORD_SIZE, "uncached word size");
        end
        check_size(mem_model.sizes[n0 + 3], 3'd1, "uncached halfword size");
        cfg_read(2'd1, v);
        check_count(v, hits, "hit count while disabled");
        cfg_read(2'd2, v);
        check_count(v, misses, "miss count while disabled");
    endtask

    task automatic random_traffic();
        cache_pkg::addr_t a;
        cache_pkg::word_t d;
        cache_pkg::word_t r;
        cache_pkg::strb_t s;
        logic we;
        cfg_write(32'd1);
        stall_on = 1'b1;
        for (int i = 0; i < 200; i++) begin
            a = rand_bits(8) << 2;    // Two tag bits, three index bits, three word bits.
            r = rand_bits(1);
            we = r[0];
            d = rand_bits(32);
            r = rand_bits(4);
            s = r[3:0];
            if (we) begin
                store_word(a, d, s);
            end else begin
                load_expect(a, "random load");
            end
        end
        stall_on = 1'b0;
    endtask

    initial begin
        rstn = 1'b0;
        stall = 1'b0;
        stall_on = 1'b0;
        cpu_req = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        cpu_size = axi_pkg::WORD_SIZE;
        cfg_wr = 1'b0;
        cfg_addr = 2'd0;
        cfg_wdata = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        reset_values();
        read_miss_fill();
        store_hit_merge();
        dirty_eviction();
        uncached_access();
        random_traffic();
        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog/axi_bridge.sv */
`timescale 1ns/1ps

module axi_bridge (
    input logic clk,
    input logic rstn,
    mem_req_if.bridge mem,
    output cache_pkg::addr_t araddr,
    output axi_pkg::len_t arlen,
    output axi_pkg::size_t arsize,
    output logic arvalid,
    input logic arready,
    output cache_pkg::addr_t awaddr,
    output axi_pkg::len_t awlen,
    output axi_pkg::size_t awsize,
    output logic awvalid,
    input logic awready,
    output cache_pkg::word_t wdata,
    output cache_pkg::strb_t wstrb,
    output logic wlast,
    output logic wvalid,
    input logic wready,
    input cache_pkg::word_t rdata,
    input axi_pkg::resp_t rresp,
    input logic rlast,
    input logic rvalid,
    output logic rready,
    input axi_pkg::resp_t bresp,
    input logic bvalid,
    output logic bready
);

    typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_AW, S_W, S_B} state_t;

    state_t state;
    cache_pkg::mem_req_t req_q;
    cache_pkg::addr_t addr_q;
    axi_pkg::size_t size_q;
    cache_pkg::word_t wword_q;
    cache_pkg::strb_t wstrb_q;
    cache_pkg::block_t wbuf;
    axi_pkg::len_t beat;
    cache_pkg::addr_t block_addr;
    logic issue;
    logic is_read;
    logic r_end;

    assign issue = (state == S_IDLE) && (req_q != cache_pkg::MEM_NONE);
    assign is_read = (req_q == cache_pkg::MEM_LOAD_WORD) || (req_q == cache_pkg::MEM_LOAD_BLOCK);
    assign block_addr = {addr_q[31:cache_pkg::OFFSET_BITS], {cache_pkg::OFFSET_BITS{1'b0}}};
    // A single-word read ends on its first beat.
    assign r_end = (state == S_R) && rvalid && (rlast || arlen == axi_pkg::SINGLE_LEN);
    assign mem.idle = (state == S_IDLE) && (req_q == cache_pkg::MEM_NONE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            req_q <= cache_pkg::MEM_NONE;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            wlast <= 1'b0;
            rready <= 1'b0;
            bready <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= r_end || ((state == S_B) && bvalid);
            if (mem.req != cache_pkg::MEM_NONE) begin
                req_q <= mem.req;
            end else if (issue) begin
                req_q <= cache_pkg::MEM_NONE;
            end
            case (state)
                S_IDLE: begin
                    if (issue && is_read) begin
                        arvalid <= 1'b1;
                        state <= S_AR;
                    end else if (issue) begin
                        awvalid <= 1'b1;
                        state <= S_AW;
                    end
                end
                S_AR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (r_end) begin
                        rready <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                S_AW: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid <= 1'b1;
                        wlast <= (awlen == axi_pkg::SINGLE_LEN);
                        state <= S_W;
                    end
                end
                S_W: begin
                    if (wready && wlast) begin
                        wvalid <= 1'b0;
                        wlast <= 1'b0;
                        bready <= 1'b1;
                        state <= S_B;
                    end else if (wready) begin
                        wlast <= (beat + 8'd1 == awlen);    // Next beat is the final one.
                    end
                end
                S_B: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req != cache_pkg::MEM_NONE) begin
            addr_q <= mem.addr;
            size_q <= mem.size;
            wword_q <= mem.wword;
            wstrb_q <= mem.wstrb;
            wbuf <= mem.wblock;
        end
        if (issue && req_q == cache_pkg::MEM_LOAD_BLOCK) begin
            araddr <= block_addr;
            arlen <= axi_pkg::BLOCK_LEN;
            arsize <= axi_pkg::WORD_SIZE;
        end else if (issue && req_q == cache_pkg::MEM_LOAD_WORD) begin
            araddr <= addr_q;
            arlen <= axi_pkg::SINGLE_LEN;
            arsize <= size_q;
        end else if (issue) begin
            awaddr <= (req_q == cache_pkg::MEM_STORE_BLOCK) ? block_addr : {addr_q[31:2], 2'b00};
            awlen <= (req_q == cache_pkg::MEM_STORE_BLOCK) ? axi_pkg::BLOCK_LEN : axi_pkg::SINGLE_LEN;
            awsize <= axi_pkg::WORD_SIZE;
        end
        if (state == S_AW && awready) begin
            beat <= '0;
            if (awlen == axi_pkg::SINGLE_LEN) begin
                wdata <= wword_q;
                wstrb <= wstrb_q;
            end else begin
                wdata <= wbuf[31:0];
                wstrb <= '1;
                wbuf <= {32'b0, wbuf[255:32]};
            end
        end else if (state == S_W && wready && !wlast) begin
            beat <= beat + 8'd1;
            wdata <= wbuf[31:0];
            wbuf <= {32'b0, wbuf[255:32]};
        end
        if (state == S_R && rvalid) begin
            mem.rword <= rdata;
            mem.rblock <= {rdata, mem.rblock[255:32]};    // Beats arrive low word first.
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid);
    a_wlast: assert property (@(posedge clk) disable iff (!rstn) wlast |-> wvalid);
    a_req_idle: assert property (@(posedge clk) disable iff (!rstn)
        mem.req != cache_pkg::MEM_NONE |-> mem.idle);
    a_rresp: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && rready |-> rresp == axi_pkg::RESP_OKAY);
    a_bresp: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && bready |-> bresp == axi_pkg::RESP_OKAY);

endmodule

/* verilog/axi_pkg.sv */
package axi_pkg;

    typedef logic [7:0] len_t;     // Beat count minus one.
    typedef logic [2:0] size_t;    // Bytes per beat as a power of two.
    typedef logic [1:0] resp_t;

    localparam len_t BLOCK_LEN = 8'd7;
    localparam len_t SINGLE_LEN = 8'd0;
    localparam size_t WORD_SIZE = 3'd2;

    localparam resp_t RESP_OKAY = 2'b00;

endpackage

/* verilog/cache_cfg.sv */
`timescale 1ns/1ps

module cache_cfg (
    input logic clk,
    input logic rstn,
    input logic cfg_wr,
    input logic [1:0] cfg_addr,
    input cache_pkg::word_t cfg_wdata,
    output cache_pkg::word_t cfg_rdata,
    output logic enable,
    input logic hit,
    input logic miss
);

    cache_pkg::word_t hit_cnt;
    cache_pkg::word_t miss_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            enable <= 1'b0;
            hit_cnt <= '0;
            miss_cnt <= '0;
        end else begin
            if (cfg_wr) begin
                enable <= cfg_wdata[0];
            end
            // Counters stop at all ones.
            if (enable && hit && hit_cnt != '1) begin
                hit_cnt <= hit_cnt + 32'd1;
            end
            if (enable && miss && miss_cnt != '1) begin
                miss_cnt <= miss_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            2'd0: cfg_rdata = {31'b0, enable};
            2'd1: cfg_rdata = hit_cnt;
            2'd2: cfg_rdata = miss_cnt;
            default: cfg_rdata = '0;
        endcase
    end

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int NUM_LINES = 8
) (
    input logic clk,
    input logic rstn,
    input logic cpu_req,
    input logic cpu_we,
    input cache_pkg::addr_t cpu_addr,
    input cache_pkg::word_t cpu_wdata,
    input cache_pkg::strb_t cpu_wstrb,
    input axi_pkg::size_t cpu_size,
    output logic cpu_ready,
    output logic cpu_done,
    output cache_pkg::word_t cpu_rdata,
    input logic enable,
    output logic hit,
    output logic miss,
    mem_req_if.ctrl mem
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = 32 - IDX_W - cache_pkg::OFFSET_BITS;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_WB, S_FILL, S_UNC} state_t;

    state_t state;
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;
    tag_t tag_arr [NUM_LINES];
    cache_pkg::block_t data_arr [NUM_LINES];

    cache_pkg::addr_t addr_q;
    cache_pkg::word_t wdata_q;
    cache_pkg::strb_t wstrb_q;
    axi_pkg::size_t size_q;
    logic we_q;
    logic en_q;

    index_t idx;
    tag_t tag;
    cache_pkg::word_sel_t sel;
    logic lookup_hit;
    logic victim_dirty;
    logic line_write;
    logic finish;
    cache_pkg::block_t base_line;
    cache_pkg::block_t merged_line;

    function automatic cache_pkg::block_t merge_word(
        input cache_pkg::block_t line,
        input cache_pkg::word_sel_t w,
        input cache_pkg::word_t data,
        input cache_pkg::strb_t strb
    );
        cache_pkg::block_t result;
        result = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[{w, 5'b0} + b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        return result;
    endfunction

    assign idx = addr_q[cache_pkg::OFFSET_BITS +: IDX_W];
    assign tag = addr_q[31 -: TAG_W];
    assign sel = addr_q[4:2];
    assign lookup_hit = valid[idx] && (tag_arr[idx] == tag);
    assign victim_dirty = valid[idx] && dirty[idx];
    assign hit = (state == S_LOOKUP) && en_q && lookup_hit;
    assign miss = (state == S_LOOKUP) && en_q && !lookup_hit;
    assign cpu_ready = (state == S_IDLE);

    // During a fill the incoming block replaces the stored line.
    assign base_line = (state == S_FILL) ? mem.rblock : data_arr[idx];
    assign merged_line = merge_word(base_line, sel, wdata_q, wstrb_q);
    assign line_write = (hit && we_q) || (state == S_FILL && mem.done);
    assign finish = hit || ((state == S_FILL || state == S_UNC) && mem.done);

    assign mem.addr = (miss && victim_dirty) ?
        {tag_arr[idx], idx, {cache_pkg::OFFSET_BITS{1'b0}}} : addr_q;
    assign mem.wblock = data_arr[idx];
    assign mem.wword = wdata_q;
    assign mem.wstrb = wstrb_q;
    assign mem.size = size_q;

    always_comb begin
        mem.req = cache_pkg::MEM_NONE;
        if (state == S_LOOKUP && !en_q) begin
            mem.req = we_q ? cache_pkg::MEM_STORE_WORD : cache_pkg::MEM_LOAD_WORD;
        end else if (miss && victim_dirty) begin
            mem.req = cache_pkg::MEM_STORE_BLOCK;
        end else if (miss || (state == S_WB && mem.done)) begin
            mem.req = cache_pkg::MEM_LOAD_BLOCK;    // Fill follows the write-back directly.
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            valid <= '0;
            dirty <= '0;
            cpu_done <= 1'b0;
        end else begin
            cpu_done <= finish;
            if (line_write) begin
                valid[idx] <= 1'b1;
                dirty[idx] <= we_q;
            end
            case (state)
                S_IDLE: if (cpu_req) state <= S_LOOKUP;
                S_LOOKUP: begin
                    if (!en_q) state <= S_UNC;
                    else if (lookup_hit) state <= S_IDLE;
                    else if (victim_dirty) state <= S_WB;
                    else state <= S_FILL;
                end
                S_WB: if (mem.done) state <= S_FILL;
                S_FILL, S_UNC: if (mem.done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req && cpu_ready) begin
            addr_q <= cpu_addr;
            we_q <= cpu_we;
            wdata_q <= cpu_wdata;
            wstrb_q <= cpu_wstrb;
            size_q <= cpu_size;
            en_q <= enable;    // Enable is sampled once per access.
        end
        if (line_write) begin
            tag_arr[idx] <= tag;
            data_arr[idx] <= we_q ? merged_line : base_line;
        end
        if (finish) begin
            cpu_rdata <= (state == S_UNC) ? mem.rword : base_line[{sel, 5'b0} +: 32];
        end
    end

    a_req_idle: assert property (@(posedge clk) disable iff (!rstn)
        mem.req != cache_pkg::MEM_NONE |-> mem.idle);

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;
    typedef logic [255:0] block_t;    // Word 0 sits in bits 31:0.

    // Byte offset bits inside one line of eight words.
    localparam int OFFSET_BITS = 5;

    typedef logic [2:0] word_sel_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LOAD_WORD,
        MEM_STORE_WORD,
        MEM_LOAD_BLOCK,
        MEM_STORE_BLOCK
    } mem_req_t;

endpackage

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_LINES = 8
) (
    input logic clk,
    input logic rstn,
    input logic cpu_req,
    input logic cpu_we,
    input cache_pkg::addr_t cpu_addr,
    input cache_pkg::word_t cpu_wdata,
    input cache_pkg::strb_t cpu_wstrb,
    input axi_pkg::size_t cpu_size,
    output logic cpu_ready,
    output logic cpu_done,
    output cache_pkg::word_t cpu_rdata,
    input logic cfg_wr,
    input logic [1:0] cfg_addr,
    input cache_pkg::word_t cfg_wdata,
    output cache_pkg::word_t cfg_rdata,
    output cache_pkg::addr_t araddr,
    output axi_pkg::len_t arlen,
    output axi_pkg::size_t arsize,
    output logic arvalid,
    input logic arready,
    output cache_pkg::addr_t awaddr,
    output axi_pkg::len_t awlen,
    output axi_pkg::size_t awsize,
    output logic awvalid,
    input logic awready,
    output cache_pkg::word_t wdata,
    output cache_pkg::strb_t wstrb,
    output logic wlast,
    output logic wvalid,
    input logic wready,
    input cache_pkg::word_t rdata,
    input axi_pkg::resp_t rresp,
    input logic rlast,
    input logic rvalid,
    output logic rready,
    input axi_pkg::resp_t bresp,
    input logic bvalid,
    output logic bready
);

    logic enable;
    logic hit;
    logic miss;

    mem_req_if mem ();

    cache_cfg u_cfg (
        .clk(clk),
        .rstn(rstn),
        .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .enable(enable),
        .hit(hit),
        .miss(miss)
    );

    cache_ctrl #(
        .NUM_LINES(NUM_LINES)
    ) u_ctrl (
        .clk(clk),
        .rstn(rstn),
        .cpu_req(cpu_req),
        .cpu_we(cpu_we),
        .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata),
        .cpu_wstrb(cpu_wstrb),
        .cpu_size(cpu_size),
        .cpu_ready(cpu_ready),
        .cpu_done(cpu_done),
        .cpu_rdata(cpu_rdata),
        .enable(enable),
        .hit(hit),
        .miss(miss),
        .mem(mem.ctrl)
    );

    axi_bridge u_bridge (
        .clk(clk),
        .rstn(rstn),
        .mem(mem.bridge),
        .araddr(araddr),
        .arlen(arlen),
        .arsize(arsize),
        .arvalid(arvalid),
        .arready(arready),
        .awaddr(awaddr),
        .awlen(awlen),
        .awsize(awsize),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wlast(wlast),
        .wvalid(wvalid),
        .wready(wready),
        .rdata(rdata),
        .rresp(rresp),
        .rlast(rlast),
        .rvalid(rvalid),
        .rready(rready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready)
    );

endmodule

/* verilog/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;

    cache_pkg::mem_req_t req;    // One-cycle strobe, raised only while idle.
    cache_pkg::addr_t addr;
    cache_pkg::block_t wblock;
    cache_pkg::word_t wword;
    cache_pkg::strb_t wstrb;
    axi_pkg::size_t size;

    cache_pkg::block_t rblock;
    cache_pkg::word_t rword;
    logic done;                  // Pulses when the bus transaction ends.
    logic idle;

    modport ctrl (
        output req, addr, wblock, wword, wstrb, size,
        input rblock, rword, done, idle
    );

    modport bridge (
        input req, addr, wblock, wword, wstrb, size,
        output rblock, rword, done, idle
    );

endinterface
